// File: hdl/kbd_pkg.sv
// Keyboard front end shared definitions
// Scan-code prefixes, receiver tuning constants, the key event passed
// from the scan decoder to the key mapper and the game control word
package kbd_pkg;

    // Scan-code prefixes
    localparam logic [7:0] ps2_prefix_ext = 8'he0;    // Extended key follows
    localparam logic [7:0] ps2_prefix_brk = 8'hf0;    // Key released

    // Receiver tuning
    localparam int ps2_sync_stages = 2;               // Metastability flops
    localparam int ps2_filter_len  = 8;               // High cycles before a fall counts
    localparam logic [15:0] ps2_idle_max = 16'd20000; // Partial frame timeout in clk cycles

    // One decoded key event
    typedef struct packed {
        logic       extended;   // E0 seen before the code
        logic       released;   // F0 seen before the code
        logic [7:0] code;       // Raw scan code
    } key_event_t;

    // Game control word, one bit per mapped key
    typedef struct packed {
        logic [9:0] joy1;         // Buttons 6..1, up, down, left, right
        logic [9:0] joy2;         // Same order as joy1
        logic [6:0] joy3;         // Buttons 3..1, up, down, left, right
        logic [3:0] start;        // Player starts 4..1
        logic [3:0] coin;         // Coin slots 4..1
        logic       reset;
        logic       pause;
        logic       test;
        logic       service;
        logic [3:0] gfx;          // Layer enables OBJ, SCR2, SCR1, CHAR
        logic       debug_plus;
        logic       debug_minus;
    } game_ctrl_t;

endpackage

// File: hdl/ps2_rx.sv
// PS/2 serial receiver
// Brings keyboard clock and data into the clk domain, accepts a falling
// clock edge only after a long enough high time and gathers 11-bit frames.
// Each frame is checked for start, odd parity and stop bits; a stalled
// partial frame is dropped so the receiver lines up with the next one
module ps2_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_error
);
    import kbd_pkg::*;

    logic [ps2_sync_stages-1:0] clk_sync;    // Clock synchronizer chain
    logic [ps2_sync_stages-1:0] data_sync;   // Data synchronizer chain
    logic [ps2_filter_len-1:0]  clk_hist;    // Recent synchronized clock samples
    logic                       clk_s;
    logic                       data_s;
    logic                       fall;        // Accepted falling edge
    logic [9:0]                 frame;       // Bits gathered so far, oldest at 0
    logic [10:0]                frame_nxt;   // Frame including current sample
    logic [3:0]                 bit_cnt;     // Bits already in the frame
    logic [15:0]                idle_cnt;    // Cycles since last edge
    logic                       frame_ok;

    assign clk_s     = clk_sync[ps2_sync_stages-1];
    assign data_s    = data_sync[ps2_sync_stages-1];
    assign fall      = ~clk_s & (&clk_hist);            // Low after a full high window
    assign frame_nxt = {data_s, frame};                 // LSB arrives first
    assign frame_ok  = ~frame_nxt[0] & frame_nxt[10]    // Start low, stop high
                     & (^frame_nxt[9:1]);               // Odd parity over data+parity

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;                            // Bus idles high
            data_sync <= '1;
            clk_hist  <= '0;
        end else begin
            clk_sync  <= {clk_sync[ps2_sync_stages-2:0], ps2_clk};
            data_sync <= {data_sync[ps2_sync_stages-2:0], ps2_data};
            clk_hist  <= {clk_hist[ps2_filter_len-2:0], clk_s};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;                           // Single-cycle pulses
            rx_error <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin             // Stop bit sampled
                    bit_cnt  <= '0;
                    rx_valid <= frame_ok;
                    rx_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == ps2_idle_max) begin     // Keyboard went quiet mid-frame
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) frame <= frame_nxt[10:1];
        if (fall && bit_cnt == 4'd10) rx_byte <= frame_nxt[8:1];
    end

endmodule

// File: hdl/ps2_scan_decode.sv
// PS/2 scan-code decoder
// Folds the E0 and F0 prefixes into flags and emits one key event
// for every completed scan code
module ps2_scan_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          rx_byte,
    input  logic                rx_valid,
    output kbd_pkg::key_event_t evt,
    output logic                evt_valid
);
    import kbd_pkg::*;

    logic ext_seen;    // E0 pending
    logic brk_seen;    // F0 pending
    logic is_ext;
    logic is_brk;
    logic is_code;     // Byte completes a scan code

    assign is_ext  = rx_byte == ps2_prefix_ext;
    assign is_brk  = rx_byte == ps2_prefix_brk;
    assign is_code = rx_valid & ~is_ext & ~is_brk;

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_seen  <= 1'b0;
            brk_seen  <= 1'b0;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= is_code;
            if (rx_valid) begin
                if (is_ext) begin
                    ext_seen <= 1'b1;
                end else if (is_brk) begin
                    brk_seen <= 1'b1;
                end else begin
                    ext_seen <= 1'b0;                  // Prefixes consumed
                    brk_seen <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_code) begin
            evt.extended <= ext_seen;
            evt.released <= brk_seen;
            evt.code     <= rx_byte;
        end
    end

endmodule

// File: hdl/key_map.sv
// Key to game control mapper
// Looks up each key event in the arcade key table and drives the mapped
// control bit high on make and low on break. Unknown keys are ignored.
// shift is raised by either shift key
module key_map (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::key_event_t evt,
    input  logic                evt_valid,
    output kbd_pkg::game_ctrl_t ctrl,
    output logic                shift
);
    logic       down;    // Level for the mapped bits
    logic [8:0] key;     // Extended flag above the scan code

    assign down  = ~evt.released;
    assign key   = {evt.extended, evt.code};
    assign shift = ctrl.joy1[7] | ctrl.joy3[5];    // Left or right shift

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (evt_valid) begin
            case (key)
                // Joystick 1
                9'h0_22: ctrl.joy1[9] <= down;     // Button 6 (X)
                9'h0_1a: ctrl.joy1[8] <= down;     // Button 5 (Z)
                9'h0_12: ctrl.joy1[7] <= down;     // Button 4 (L shift)
                9'h0_29: ctrl.joy1[6] <= down;     // Button 3 (space)
                9'h0_11: ctrl.joy1[5] <= down;     // Button 2 (alt)
                9'h0_14: ctrl.joy1[4] <= down;     // Button 1 (L ctrl)
                9'h1_75: ctrl.joy1[3] <= down;     // Up arrow
                9'h1_72: ctrl.joy1[2] <= down;     // Down arrow
                9'h1_6b: ctrl.joy1[1] <= down;     // Left arrow
                9'h1_74: ctrl.joy1[0] <= down;     // Right arrow
                // Joystick 2
                9'h0_24: ctrl.joy2[8] <= down;     // Button 5 (E)
                9'h0_1d: ctrl.joy2[7] <= down;     // Button 4 (W)
                9'h0_15: ctrl.joy2[6] <= down;     // Button 3 (Q)
                9'h0_1b: ctrl.joy2[5] <= down;     // Button 2 (S)
                9'h0_1c: ctrl.joy2[4] <= down;     // Button 1 (A)
                9'h0_2d: ctrl.joy2[3] <= down;     // Up (R)
                9'h0_2b: ctrl.joy2[2] <= down;     // Down (F)
                9'h0_23: ctrl.joy2[1] <= down;     // Left (D)
                9'h0_34: ctrl.joy2[0] <= down;     // Right (G)
                // Joystick 3
                9'h0_5a: ctrl.joy3[6] <= down;     // Button 3 (return)
                9'h0_59: ctrl.joy3[5] <= down;     // Button 2 (R shift)
                9'h1_14: ctrl.joy3[4] <= down;     // Button 1 (R ctrl)
                9'h0_43: ctrl.joy3[3] <= down;     // Up (I)
                9'h0_42: begin                     // K serves two players
                    ctrl.joy3[2] <= down;          // 3P down
                    ctrl.joy2[9] <= down;          // 2P button 6
                end
                9'h0_3b: ctrl.joy3[1] <= down;     // Left (J)
                9'h0_4b: ctrl.joy3[0] <= down;     // Right (L)
                // Coins
                9'h0_2e: ctrl.coin[0] <= down;     // 5
                9'h0_36: ctrl.coin[1] <= down;     // 6
                9'h0_3d: ctrl.coin[2] <= down;     // 7
                9'h0_3e: ctrl.coin[3] <= down;     // 8
                // Starts
                9'h0_16: ctrl.start[0] <= down;    // 1
                9'h0_1e: ctrl.start[1] <= down;    // 2
                9'h0_26: ctrl.start[2] <= down;    // 3
                9'h0_25: ctrl.start[3] <= down;    // 4
                // System keys
                9'h0_4d: ctrl.pause   <= down;     // P
                9'h0_06: ctrl.test    <= down;     // F2
                9'h0_04: ctrl.reset   <= down;     // F3
                9'h0_46: ctrl.service <= down;     // 9
                // Graphics layer enables
                9'h0_83: ctrl.gfx[0] <= down;      // F7 char layer
                9'h0_0a: ctrl.gfx[1] <= down;      // F8 scroll 1
                9'h0_01: ctrl.gfx[2] <= down;      // F9 scroll 2
                9'h0_09: ctrl.gfx[3] <= down;      // F10 objects
                // Debug stepping
                9'h0_5b: ctrl.debug_plus  <= down;
                9'h0_4a: ctrl.debug_minus <= down;
                default: ;                         // Unmapped key
            endcase
        end
    end

endmodule

// File: hdl/ctrl_snapshot.sv
// Host snapshot port for the control word
// Four-phase req/ack handshake; ctrl is captured on the first request
// cycle and held on snap_ctrl until the host drops the request
module ctrl_snapshot (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::game_ctrl_t ctrl,
    input  logic                snap_req,
    output logic                snap_ack,
    output kbd_pkg::game_ctrl_t snap_ctrl
);
    logic holding;    // Second FSM state, snapshot taken

    always_ff @(posedge clk) begin
        if (rst) begin
            holding   <= 1'b0;
            snap_ack  <= 1'b0;
            snap_ctrl <= '0;
        end else if (!holding) begin
            snap_ack <= 1'b0;
            if (snap_req) begin                    // Request seen with ack low
                snap_ctrl <= ctrl;
                holding   <= 1'b1;
            end
        end else begin
            if (snap_req) begin
                snap_ack <= 1'b1;                  // One cycle after capture
            end else begin
                snap_ack <= 1'b0;                  // Host released
                holding  <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/kbd_ctrl_top.sv
// PS/2 keyboard front end for the arcade core
// Receiver, scan decoder and key mapper feed the game control word,
// which a host can sample through the snapshot port
module kbd_ctrl_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::game_ctrl_t ctrl,
    output logic                shift,
    output logic                rx_error,
    input  logic                snap_req,
    output logic                snap_ack,
    output kbd_pkg::game_ctrl_t snap_ctrl
);
    import kbd_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    key_event_t evt;          // Decoded key
    logic       evt_valid;

    ps2_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    ps2_scan_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .evt       (evt),
        .evt_valid (evt_valid)
    );

    key_map u_map (
        .clk       (clk),
        .rst       (rst),
        .evt       (evt),
        .evt_valid (evt_valid),
        .ctrl      (ctrl),
        .shift     (shift)
    );

    ctrl_snapshot u_snap (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .snap_req  (snap_req),
        .snap_ack  (snap_ack),
        .snap_ctrl (snap_ctrl)
    );

endmodule

// File: bench/kbd_tb_model.svh
// Keyboard testbench model
// PS/2 frame driver, a key table kept apart from the DUT, the reference
// mapping of key events onto the control word and the value compare
`ifndef kbd_tb_model_svh
`define kbd_tb_model_svh

// One 9-bit entry per control bit, top of the word first, bit 8 is the E0 flag
localparam int key_count = $bits(game_ctrl_t);
localparam logic [9*key_count-1:0] key_table = {
    9'h022, 9'h01a, 9'h012, 9'h029, 9'h011, 9'h014,          // joy1 buttons 6..1
    9'h175, 9'h172, 9'h16b, 9'h174,                          // joy1 E0 arrows
    9'h042, 9'h024, 9'h01d, 9'h015, 9'h01b, 9'h01c,          // joy2 buttons, K first
    9'h02d, 9'h02b, 9'h023, 9'h034,                          // joy2 R F D G
    9'h05a, 9'h059, 9'h114, 9'h043, 9'h042, 9'h03b, 9'h04b,  // joy3, K again
    9'h025, 9'h026, 9'h01e, 9'h016,                          // Starts 4..1
    9'h03e, 9'h03d, 9'h036, 9'h02e,                          // Coins 4..1
    9'h004, 9'h04d, 9'h006, 9'h046,                          // F3 P F2 9
    9'h009, 9'h001, 9'h00a, 9'h083,                          // F10 F9 F8 F7
    9'h05b, 9'h04a                                           // Debug plus, minus
};

// Print the reason, then the fail message, then stop
task automatic fail_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "Run stopped on error");
endtask

task automatic check_val(input string name, input logic [63:0] got,
                         input logic [63:0] exp);
    if (got !== exp)
        fail_run($sformatf("Fail %s got %h expected %h", name, got, exp));
endtask

// One 11-bit frame, 20 clk per PS/2 clock, data changes while clock high
task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};  // Stop, odd parity, data, start
    for (i = 0; i < 11; i++) begin
        @(posedge clk);
        ps2_data <= bits[i];
        repeat (5) @(posedge clk);
        ps2_clk <= 1'b0;                                 // Device samples on the fall
        repeat (10) @(posedge clk);
        ps2_clk <= 1'b1;
        repeat (4) @(posedge clk);
    end
    ps2_data <= 1'b1;                                    // Bus back to idle
    repeat (frame_gap) @(posedge clk);
endtask

// Control bits touched by one key, zero for an unmapped key
function automatic game_ctrl_t key_mask(input logic ext, input logic [7:0] code);
    logic [key_count-1:0] mask;
    int                   i;
    mask = '0;
    for (i = 0; i < key_count; i++)
        if (key_table[9*i +: 9] == {ext, code})
            mask[i] = 1'b1;
    key_mask = mask;
endfunction

// Expected control word after one key event
function automatic game_ctrl_t ref_map(input game_ctrl_t cur, input logic ext,
                                       input logic rel, input logic [7:0] code);
    game_ctrl_t mask;
    mask = key_mask(ext, code);
    if (rel)
        ref_map = cur & ~mask;                           // Break clears
    else
        ref_map = cur | mask;                            // Make sets
endfunction

`endif

// File: bench/kbd_ctrl_tb.sv
// Testbench for the PS/2 keyboard front end
// Sends make and break codes as PS/2 frames, walks the whole key table,
// runs a seeded random key sequence, injects a parity error and exercises
// the host snapshot handshake against a reference key map
module kbd_ctrl_tb;
    import kbd_pkg::*;

    localparam int frame_gap  = 40;                     // Settle cycles after each frame
    localparam int max_frames = 1100;                   // Directed keys plus 3 per random key
    localparam int limit      = max_frames * 300 + 2000;

    logic       clk = 1'b0;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic       snap_req;
    game_ctrl_t ctrl;
    logic       shift;
    logic       rx_error;
    logic       snap_ack;
    game_ctrl_t snap_ctrl;

    game_ctrl_t model;                                  // Expected control word
    game_ctrl_t snap_model;                             // Expected snapshot
    int         err_count;                              // rx_error pulses seen
    int         exp_errs;
    int         cycles = 0;
    event       cmp_ev;

    `include "kbd_tb_model.svh"

    kbd_ctrl_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .ctrl      (ctrl),
        .shift     (shift),
        .rx_error  (rx_error),
        .snap_req  (snap_req),
        .snap_ack  (snap_ack),
        .snap_ctrl (snap_ctrl)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst)
            err_count <= 0;
        else if (rx_error)
            err_count <= err_count + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == limit)
            fail_run($sformatf("Timeout, tests not done after %0d cycles", limit));
    end

    // Compare after every key event
    always @(cmp_ev) begin
        check_val("ctrl", ctrl, model);
        check_val("shift", shift, model.joy1[7] | model.joy3[5]);  // Either shift key
        check_val("rx_error count", err_count, exp_errs);
    end

    task automatic send_key(input logic ext, input logic rel, input logic [7:0] code);
        if (ext)
            send_frame(ps2_prefix_ext, 1'b0);
        if (rel)
            send_frame(ps2_prefix_brk, 1'b0);
        send_frame(code, 1'b0);
        model = ref_map(model, ext, rel, code);
        -> cmp_ev;
    endtask

    initial begin : run
        int unsigned seed;
        int          idx;
        int          n;
        logic [8:0]  key;
        logic        ext;
        logic        rel;
        logic [7:0]  code;
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        snap_req = 1'b0;
        model    = '0;
        exp_errs = 0;
        seed     = $urandom(63788);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);                     // Edge filter fills with idle high
        -> cmp_ev;                                      // Reset state
        check_val("snap_ack", snap_ack, 0);
        check_val("snap_ctrl", snap_ctrl, 0);

        for (idx = 0; idx < key_count; idx++) begin     // Make and break every key
            key = key_table[9*idx +: 9];
            send_key(key[8], 1'b0, key[7:0]);
            send_key(key[8], 1'b1, key[7:0]);
        end
        send_key(1'b0, 1'b0, 8'h75);                    // Keypad 8, not the up arrow
        send_key(1'b0, 1'b0, 8'h6b);
        send_key(1'b0, 1'b1, 8'h75);
        send_key(1'b0, 1'b1, 8'h6b);

        send_key(1'b0, 1'b0, 8'h42);                    // K drives two players
        check_val("ctrl.joy2[9]", ctrl.joy2[9], 1);
        check_val("ctrl.joy3[2]", ctrl.joy3[2], 1);
        send_key(1'b0, 1'b1, 8'h42);
        check_val("ctrl.joy2[9]", ctrl.joy2[9], 0);
        check_val("ctrl.joy3[2]", ctrl.joy3[2], 0);
        send_key(1'b0, 1'b0, 8'h12);                    // Left shift
        check_val("shift", shift, 1);
        send_key(1'b0, 1'b0, 8'h59);                    // Right shift overlaps
        send_key(1'b0, 1'b1, 8'h12);
        check_val("shift", shift, 1);
        send_key(1'b0, 1'b1, 8'h59);
        check_val("shift", shift, 0);

        for (n = 0; n < 300; n++) begin                 // Random keys and prefixes
            if ($urandom_range(3) != 0) begin
                idx  = $urandom_range(key_count - 1);
                key  = key_table[9*idx +: 9];
                ext  = key[8] ^ ($urandom_range(7) == 0);  // Sometimes wrong E0
                code = key[7:0];
            end else begin
                ext  = ($urandom_range(1) != 0);
                code = 8'($urandom_range(255));
                if (code == ps2_prefix_ext || code == ps2_prefix_brk)
                    code = 8'h00;
            end
            rel = ($urandom_range(1) != 0);
            send_key(ext, rel, code);
        end

        send_key(1'b0, 1'b1, 8'h1c);                    // A up, so a wrong make would show
        send_frame(8'h1c, 1'b1);                        // A with parity flipped
        exp_errs = exp_errs + 1;
        -> cmp_ev;                                      // Error counted, ctrl untouched
        send_key(1'b0, 1'b0, 8'h1c);                    // Next good frame decodes

        send_key(1'b1, 1'b0, 8'h75);                    // Up arrow held with A
        snap_model = model;
        snap_req <= 1'b1;
        n = 0;
        while (!snap_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!snap_ack)
            fail_run("snap_ack never rose after snap_req");
        check_val("snap_ack rise delay", n, 3);        // Set on 2nd edge, seen on 3rd
        check_val("snap_ctrl", snap_ctrl, snap_model);
        send_key(1'b0, 1'b1, 8'h1c);                    // Keys change while held
        send_key(1'b0, 1'b0, 8'h29);
        check_val("snap_ack", snap_ack, 1);
        check_val("snap_ctrl", snap_ctrl, snap_model);
        snap_req <= 1'b0;
        n = 0;
        while (snap_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (snap_ack)
            fail_run("snap_ack stayed high after snap_req dropped");
        check_val("snap_ack fall delay", n, 2);

        repeat (10) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+bench
hdl/kbd_pkg.sv
hdl/ps2_rx.sv
hdl/ps2_scan_decode.sv
hdl/key_map.sv
hdl/ctrl_snapshot.sv
hdl/kbd_ctrl_top.sv
bench/kbd_ctrl_tb.sv
